// File: gba_load_pkg.sv
// Download widths, load-kind enum, beat, cheat code and cart info types
`default_nettype none

package gba_load_pkg;

	// ========================================================================
	// Widths and fixed indices
	// ========================================================================

	localparam int ioctl_addr_w = 27;                 // Byte address of a download
	localparam logic [7:0] cheat_index = 8'd255;      // File index of cheat files

	// Download kind, acts as the opcode for the execute stages
	typedef enum logic [1:0] {
		load_none,                                    // No download running
		load_bios,                                    // Index 0
		load_cart,                                    // Any other index
		load_cheat                                    // Index 255
	} load_kind_e;

	// One host beat, file byte order is data[7:0] first
	typedef struct packed {
		logic [ioctl_addr_w-1:0] addr;                // Byte address
		logic [15:0]             data;
		logic                    wr;                  // Write strobe
	} ioctl_beat_t;

	// Cheat code as handed to the core, each field big-endian as received
	typedef struct packed {
		logic [31:0] flags;                           // Bits 127:96
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;                         // Bits 31:0
	} cheat_code_t;

	// Cartridge properties found while the image streams in
	typedef struct packed {
		logic                    loaded;
		logic [1:0]              cart_type;           // Index bits 7:6
		logic                    flash_1m;            // Marker string seen
		logic                    sram_quirk;
		logic                    remap_quirk;
		logic [ioctl_addr_w-2:0] last_addr;           // 16-bit word address
	} cart_info_t;

endpackage

`default_nettype wire

// File: load_decoder.sv
// Download kind decode, beat delay stage, cart start and cheat clear pulses
`timescale 1ns/100ps
`default_nettype none

module load_decoder (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire                            ioctl_download,
	input  wire [7:0]                      ioctl_index,
	input  wire gba_load_pkg::ioctl_beat_t beat_in,
	output gba_load_pkg::load_kind_e       kind,         // Aligned with beat
	output gba_load_pkg::ioctl_beat_t      beat,         // Beat delayed one stage
	output logic                           cart_start,   // First cycle of a cart load
	output logic [1:0]                     cart_type,
	output logic                           cheat_clear   // First cycle of a cheat load
);
	import gba_load_pkg::*;

	load_kind_e kind_next;
	logic       cart_rise;
	logic       cheat_rise;

	// Index decode, only done here
	always_comb begin
		if (!ioctl_download)
			kind_next = load_none;
		else if (ioctl_index == 8'd0)
			kind_next = load_bios;
		else if (ioctl_index == cheat_index)
			kind_next = load_cheat;
		else
			kind_next = load_cart;
	end

	// The kind register holds the previous kind for edge detect
	assign cart_rise  = (kind_next == load_cart) && (kind != load_cart);
	assign cheat_rise = (kind_next == load_cheat) && (kind != load_cheat);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kind        <= load_none;
			cart_start  <= 1'b0;
			cheat_clear <= 1'b0;
			cart_type   <= 2'd0;
		end else begin
			kind        <= kind_next;
			cart_start  <= cart_rise;
			cheat_clear <= cheat_rise;
			if (cart_rise)
				cart_type <= ioctl_index[7:6];      // Type lives in the top index bits
		end
	end

	// Beat pipeline stage, only the strobe is cleared
	always_ff @(posedge clk_sys) begin
		beat <= beat_in;
		if (reset)
			beat.wr <= 1'b0;
	end

endmodule

`default_nettype wire

// File: bios_packer.sv
// BIOS half-word pairing into 32-bit RAM writes
`timescale 1ns/100ps
`default_nettype none

module bios_packer #(
	parameter int bios_aw = 12                          // Word address bits, 16 KB
) (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire gba_load_pkg::load_kind_e  kind,
	input  wire gba_load_pkg::ioctl_beat_t beat,
	output logic                           bios_wr,
	output logic [bios_aw-1:0]             bios_addr,   // 32-bit word address
	output logic [31:0]                    bios_data
);
	import gba_load_pkg::*;

	logic        hit;
	logic [15:0] low_half;                              // Waits for its partner beat

	assign hit = (kind == load_bios) && beat.wr;

	always_ff @(posedge clk_sys) begin
		if (hit) begin
			if (!beat.addr[1]) begin
				low_half <= beat.data;                      // Lower half of the word
			end else begin
				bios_data <= {beat.data, low_half};
				bios_addr <= beat.addr[bios_aw+1:2];
			end
		end
	end

	// One write per completed word
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= hit && beat.addr[1];
	end

endmodule

`default_nettype wire

// File: cheat_assembler.sv
// Cheat code assembly from eight half-word beats with a valid pulse
`timescale 1ns/100ps
`default_nettype none

module cheat_assembler (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire gba_load_pkg::load_kind_e  kind,
	input  wire gba_load_pkg::ioctl_beat_t beat,
	output gba_load_pkg::cheat_code_t      cheat_code,
	output logic                           cheat_valid
);
	import gba_load_pkg::*;

	logic hit;

	assign hit = (kind == load_cheat) && beat.wr;

	// ========================================================================
	// Field steering, 16 bytes per code, low half-word of each field first
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (hit) begin
			case (beat.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= beat.data;
				4'd2:  cheat_code.flags[31:16]   <= beat.data;
				4'd4:  cheat_code.address[15:0]  <= beat.data;
				4'd6:  cheat_code.address[31:16] <= beat.data;
				4'd8:  cheat_code.compare[15:0]  <= beat.data;
				4'd10: cheat_code.compare[31:16] <= beat.data;
				4'd12: cheat_code.replace[15:0]  <= beat.data;
				4'd14: cheat_code.replace[31:16] <= beat.data; // Completes the code
				default: ;                                     // Odd offsets never arrive
			endcase
		end
	end

	// Pulse as the last field lands
	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= hit && (beat.addr[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

// File: cart_scanner.sv
// Cart image scan for flash marker, last address, header title and quirk match
`timescale 1ns/100ps
`default_nettype none

module cart_scanner (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire gba_load_pkg::load_kind_e  kind,
	input  wire gba_load_pkg::ioctl_beat_t beat,
	input  wire                            cart_start,
	input  wire [1:0]                      cart_type,
	output gba_load_pkg::cart_info_t       cart_info
);
	import gba_load_pkg::*;

	localparam int quirk_n = 6;

	// Titles as they sit in the header, zero padded to 12 bytes
	localparam logic [95:0] quirk_title [quirk_n] = '{
		"ROCKY BOXING",
		"DBZ TAIKETSU",
		{"CASTLEVANIA", 8'h00},
		{"SUPER MARIO", 8'h00},
		{"MAPPY", 56'h00000000000000},
		{"ZELDA 1", 40'h0000000000}
	};
	localparam logic [quirk_n-1:0] quirk_remap = 6'b111100; // NES classics need remap

	logic        hit;
	logic        hdr_row;                          // Beat in header bytes 0xA0..0xAF
	logic [6:0]  title_lsb;                        // Bit position of this half-word
	logic [63:0] hist_base;
	logic        marker_even;                      // Marker starts at even byte
	logic        marker_odd;                       // Marker starts at odd byte
	logic        sram_hit;
	logic        remap_hit;
	logic [63:0] hist;                             // Last eight file bytes
	logic [95:0] title;                            // First byte in the top bits

	assign hit       = (kind == load_cart) && beat.wr;
	assign hdr_row   = (beat.addr[ioctl_addr_w-1:4] == 23'h00000A);
	assign title_lsb = {4'd10 - beat.addr[3:0], 3'd0};
	assign hist_base = cart_start ? 64'd0 : hist;  // Forget the previous image

	// ========================================================================
	// Marker search, both byte alignments checked on every beat
	// ========================================================================

	assign marker_even = ({hist_base, beat.data[7:0]} == "FLASH1M_V");
	assign marker_odd  = ({hist_base[55:0], beat.data[7:0], beat.data[15:8]} == "FLASH1M_V");

	// Quirk table lookup on the captured title
	always_comb begin
		sram_hit  = 1'b0;
		remap_hit = 1'b0;
		for (int i = 0; i < quirk_n; i++) begin
			if (title == quirk_title[i]) begin
				sram_hit  = 1'b1;                          // Every entry needs SRAM quirk
				remap_hit = quirk_remap[i];
			end
		end
	end

	// Byte history and title capture
	always_ff @(posedge clk_sys) begin
		if (hit) begin
			hist <= {hist_base[47:0], beat.data[7:0], beat.data[15:8]};
			if (hdr_row && (beat.addr[3:0] < 4'd12))
				title[title_lsb +: 16] <= {beat.data[7:0], beat.data[15:8]};
		end else if (cart_start) begin
			hist <= 64'd0;
		end
	end

	// ========================================================================
	// Result register
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_info <= '0;
		end else begin
			if (cart_start) begin
				cart_info.loaded      <= 1'b1;
				cart_info.cart_type   <= cart_type;
				cart_info.flash_1m    <= 1'b0;
				cart_info.sram_quirk  <= 1'b0;
				cart_info.remap_quirk <= 1'b0;
			end
			if (hit) begin
				cart_info.last_addr <= beat.addr[ioctl_addr_w-1:1]; // Word address
				if (marker_even || marker_odd)
					cart_info.flash_1m <= 1'b1;                       // Sticky until next cart
				if (hdr_row && (beat.addr[3:0] == 4'd12)) begin    // Title complete
					cart_info.sram_quirk  <= sram_hit;
					cart_info.remap_quirk <= remap_hit;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: cart_loader_top.sv
// Load path top level with decoder and BIOS, cheat and cart execute stages
`timescale 1ns/100ps
`default_nettype none

module cart_loader_top #(
	parameter int bios_aw = 12                          // BIOS RAM word address bits
) (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire                            ioctl_download,
	input  wire [7:0]                      ioctl_index,
	input  wire gba_load_pkg::ioctl_beat_t beat_in,
	output logic                           bios_wr,
	output logic [bios_aw-1:0]             bios_addr,
	output logic [31:0]                    bios_data,
	output logic                           cheat_clear,
	output logic                           cheat_valid,
	output gba_load_pkg::cheat_code_t      cheat_code,
	output gba_load_pkg::cart_info_t       cart_info
);
	import gba_load_pkg::*;

	load_kind_e  kind;                                  // Decoded kind, beat aligned
	ioctl_beat_t beat;                                  // Beat after decode stage
	logic        cart_start;
	logic [1:0]  cart_type;

	// Decode stage
	load_decoder load_decoder_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.beat_in        (beat_in),
		.kind           (kind),
		.beat           (beat),
		.cart_start     (cart_start),
		.cart_type      (cart_type),
		.cheat_clear    (cheat_clear)
	);

	// Execute stages, each acts on its own kind only
	bios_packer #(
		.bios_aw (bios_aw)
	) bios_packer_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kind      (kind),
		.beat      (beat),
		.bios_wr   (bios_wr),
		.bios_addr (bios_addr),
		.bios_data (bios_data)
	);

	cheat_assembler cheat_assembler_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.kind        (kind),
		.beat        (beat),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	cart_scanner cart_scanner_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.kind       (kind),
		.beat       (beat),
		.cart_start (cart_start),
		.cart_type  (cart_type),
		.cart_info  (cart_info)
	);

endmodule

`default_nettype wire

// File: tb_cart_loader_checker.sv
// Concurrent assertions on the load path outputs and their bind to the top level
`timescale 1ns/100ps
`default_nettype none

module tb_cart_loader_checker (
	input wire                           clk_sys,
	input wire                           reset,
	input wire                           bios_wr,
	input wire                           cheat_valid,
	input wire                           cheat_clear,
	input wire gba_load_pkg::cart_info_t cart_info
);

	int fail_count = 0;                                      // Failed assertion attempts

	// BIOS and cheat stages never complete together
	no_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		!(bios_wr && cheat_valid))
		else begin
			fail_count++;
			$error("bios_wr and cheat_valid high in the same cycle");
		end

	// Clear is a single cycle pulse
	clear_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_clear |=> !cheat_clear)
		else begin
			fail_count++;
			$error("cheat_clear held longer than one cycle");
		end

	// Info register is empty right after reset
	info_after_reset: assert property (@(posedge clk_sys)
		reset |=> (cart_info == '0))
		else begin
			fail_count++;
			$error("cart_info not cleared by reset");
		end

endmodule

bind cart_loader_top tb_cart_loader_checker checker_inst (.*);

`default_nettype wire

// File: tb_cart_loader.sv
// Testbench for the load path with clock, reset, directed tests, xorshift and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_cart_loader;
	import gba_load_pkg::*;

	localparam int clk_period  = 4;
	localparam int test_cycles = 3000;                      // Rough length of all tests
	localparam int watchdog_ns = 5 * test_cycles * clk_period;
	localparam int bios_aw     = 12;                        // Top level default
	localparam int img_bytes   = 320;                       // Cart image, covers the header

	logic               clk_sys;
	logic               reset;
	logic               ioctl_download;
	logic [7:0]         ioctl_index;
	ioctl_beat_t        beat_in;
	logic               bios_wr;
	logic [bios_aw-1:0] bios_addr;
	logic [31:0]        bios_data;
	logic               cheat_clear;
	logic               cheat_valid;
	cheat_code_t        cheat_code;
	cart_info_t         cart_info;

	logic [31:0] rng;                                       // xorshift state
	logic [7:0]  img [img_bytes];                           // Cart image in file order
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          bios_wr_seen = 0;                          // Pulse counters
	int          cheat_valid_seen = 0;
	int          cheat_clear_seen = 0;

	cart_loader_top cart_loader_top_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (bios_wr)
			bios_wr_seen++;
		if (cheat_valid)
			cheat_valid_seen++;
		if (cheat_clear)
			cheat_clear_seen++;
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic compare_value(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// One strobe, returns one edge after the beat was driven
	task automatic send_beat(input logic [26:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		beat_in <= {addr, data, 1'b1};
		@(posedge clk_sys);
		beat_in.wr <= 1'b0;
	endtask

	task automatic start_download(input logic [7:0] index);
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		@(posedge clk_sys);                                   // Kind is decoded now
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);                        // Gap so the next file restarts
	endtask

	// Execute stage output lands two edges after the beat
	task automatic wait_result();
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic fill_image();
		for (int i = 0; i < img_bytes; i++) begin
			rng = xorshift(rng);
			img[i] = rng[7:0];
		end
	endtask

	// Text is right aligned, first character in the top used byte
	task automatic place_text(input int offset, input logic [95:0] text, input int n);
		for (int i = 0; i < n; i++)
			img[offset + i] = text[8 * (n - 1 - i) +: 8];
	endtask

	task automatic load_cart_image(input logic [7:0] index);
		start_download(index);
		for (int i = 0; i < img_bytes; i += 2)
			send_beat(i, {img[i + 1], img[i]});                 // Low byte comes first in file
		end_download();
	endtask

	task automatic cart_check(input logic [7:0] index, input logic flash,
		input logic sram, input logic remap);
		@(negedge clk_sys);
		compare_value("cart loaded", cart_info.loaded, 1);
		compare_value("cart_type", cart_info.cart_type, index[7:6]);
		compare_value("flash_1m", cart_info.flash_1m, flash);
		compare_value("sram_quirk", cart_info.sram_quirk, sram);
		compare_value("remap_quirk", cart_info.remap_quirk, remap);
		compare_value("last_addr", cart_info.last_addr, (img_bytes - 2) / 2); // Word address
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic after_reset();
		int e0;
		e0 = errors;
		@(negedge clk_sys);
		compare_value("bios_wr after reset", bios_wr, 0);
		compare_value("cheat_valid after reset", cheat_valid, 0);
		compare_value("cheat_clear after reset", cheat_clear, 0);
		compare_value("cart_info after reset", cart_info, 0);
		tests++;
		$display("after_reset done, %0d errors", errors - e0);
	endtask

	task automatic bios_load();
		int          e0;
		int          w0;
		logic [15:0] lo;
		logic [15:0] hi;
		logic [26:0] a;
		e0 = errors;
		w0 = bios_wr_seen;
		start_download(8'd0);
		for (int i = 0; i < 64; i++) begin
			rng = xorshift(rng);
			lo = rng[15:0];
			hi = rng[31:16];
			a  = i * 4;                                         // Byte address of the word
			send_beat(a, lo);
			send_beat(a + 27'd2, hi);
			wait_result();
			compare_value("bios_wr", bios_wr, 1);
			compare_value("bios_addr", bios_addr, i);
			compare_value("bios_data", bios_data, {hi, lo});
		end
		end_download();
		compare_value("bios write count", bios_wr_seen - w0, 64);
		tests++;
		$display("bios_load done, %0d errors", errors - e0);
	endtask

	task automatic cheat_load();
		int          e0;
		int          v0;
		int          c0;
		logic [15:0] half [8];
		e0 = errors;
		v0 = cheat_valid_seen;
		c0 = cheat_clear_seen;
		start_download(cheat_index);
		for (int c = 0; c < 2; c++) begin
			for (int k = 0; k < 8; k++) begin
				rng = xorshift(rng);
				half[k] = rng[15:0];
				send_beat(c * 16 + k * 2, half[k]);
			end
			wait_result();
			compare_value("cheat_valid", cheat_valid, 1);
			compare_value("cheat flags", cheat_code.flags, {half[1], half[0]});
			compare_value("cheat address", cheat_code.address, {half[3], half[2]});
			compare_value("cheat compare", cheat_code.compare, {half[5], half[4]});
			compare_value("cheat replace", cheat_code.replace, {half[7], half[6]});
		end
		end_download();
		compare_value("cheat_clear pulses", cheat_clear_seen - c0, 1);
		compare_value("cheat_valid pulses", cheat_valid_seen - v0, 2); // One per eight beats
		tests++;
		$display("cheat_load done, %0d errors", errors - e0);
	endtask

	task automatic flash_marker();
		int e0;
		e0 = errors;
		fill_image();
		place_text(257, "FLASH1M_V", 9);                      // Odd byte offset
		load_cart_image(8'h41);
		cart_check(8'h41, 1'b1, 1'b0, 1'b0);
		fill_image();
		place_text(288, "FLASH1M_V", 9);                      // Even byte offset
		load_cart_image(8'h82);
		cart_check(8'h82, 1'b1, 1'b0, 1'b0);
		fill_image();                                         // No marker at all
		load_cart_image(8'h07);
		cart_check(8'h07, 1'b0, 1'b0, 1'b0);
		tests++;
		$display("flash_marker done, %0d errors", errors - e0);
	endtask

	task automatic quirk_and_type();
		int e0;
		e0 = errors;
		fill_image();
		place_text(8'hA0, {"CASTLEVANIA", 8'h00}, 12);
		load_cart_image(8'hC3);
		cart_check(8'hC3, 1'b0, 1'b1, 1'b1);                  // Save-RAM and remap
		fill_image();
		place_text(8'hA0, "ROCKY BOXING", 12);
		load_cart_image(8'h80);
		cart_check(8'h80, 1'b0, 1'b1, 1'b0);                  // Save-RAM only
		fill_image();
		place_text(8'hA0, "UNKNOWN GAME", 12);
		load_cart_image(8'h05);
		cart_check(8'h05, 1'b0, 1'b0, 1'b0);
		tests++;
		$display("quirk_and_type done, %0d errors", errors - e0);
	endtask

	// ========================================================================
	// Sequence and watchdog
	// ========================================================================

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		beat_in        = '0;
		rng            = 32'd91;                              // Seed
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		after_reset();
		bios_load();
		cheat_load();
		flash_marker();
		quirk_and_type();
		errors += cart_loader_top_inst.checker_inst.fail_count;
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout, the tests did not finish within %0d ns", watchdog_ns);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
gba_load_pkg.sv
load_decoder.sv
bios_packer.sv
cheat_assembler.sv
cart_scanner.sv
cart_loader_top.sv
tb_cart_loader_checker.sv
tb_cart_loader.sv
